// File: tests/ex_monitor.sv
`timescale 1ns/1ps

module ex_monitor (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          in_valid,
    input  logic                          in_allowin,
    input  logic [ex_pipe_pkg::xlen-1:0]  in_pc,
    input  logic [ex_op_pkg::op_w-1:0]    in_op,
    input  logic [ex_pipe_pkg::xlen-1:0]  in_src1,
    input  logic [ex_pipe_pkg::xlen-1:0]  in_src2,
    input  logic [ex_pipe_pkg::reg_w-1:0] in_rd,
    input  logic                          in_we,
    input  logic                          out_allowin,
    input  logic                          out_valid,
    input  logic [ex_pipe_pkg::xlen-1:0]  out_pc,
    input  logic [ex_pipe_pkg::reg_w-1:0] out_rd,
    input  logic                          out_we,
    input  logic [ex_pipe_pkg::xlen-1:0]  out_result,
    input  logic                          fwd_valid,
    input  logic [ex_pipe_pkg::reg_w-1:0] fwd_addr,
    input  logic [ex_pipe_pkg::xlen-1:0]  fwd_data,
    output int                            errors,
    output int                            delivered,
    output int                            dropped,
    output int                            pending
);
    import ex_op_pkg::*;
    import ex_pipe_pkg::*;

    result_t         q[$];  // accepted, not yet delivered
    logic [op_w-1:0] op_q[$];
    int              idx;
    string           name;

    function automatic logic [xlen-1:0] model_result(logic [op_w-1:0] op,
                                                     logic [xlen-1:0] a,
                                                     logic [xlen-1:0] b);
        longint      sa;
        longint      sb;
        logic [63:0] sp;
        logic [63:0] up;
        logic [31:0] sq;
        logic [31:0] sr;
        sa = $signed(a);
        sb = $signed(b);
        sp = sa * sb;
        up = {32'b0, a} * {32'b0, b};
        if (b == '0) begin
            sq = '1;
            sr = a;
        end else if (a == 32'h8000_0000 && b == '1) begin
            sq = a;  // overflow case
            sr = '0;
        end else begin
            sq = $signed(a) / $signed(b);
            sr = $signed(a) % $signed(b);
        end
        case (op)
            op_add:   return a + b;
            op_sub:   return a - b;
            op_slt:   return {31'b0, $signed(a) < $signed(b)};
            op_sltu:  return {31'b0, a < b};
            op_and:   return a & b;
            op_or:    return a | b;
            op_nor:   return ~(a | b);
            op_xor:   return a ^ b;
            op_sll:   return a << b[4:0];
            op_srl:   return a >> b[4:0];
            op_sra:   return $signed(a) >>> b[4:0];
            op_lui:   return b;
            op_mul:   return sp[31:0];
            op_mulh:  return sp[63:32];
            op_mulhu: return up[63:32];
            op_div:   return sq;
            op_mod:   return sr;
            op_divu:  return (b == '0) ? '1 : a / b;
            op_modu:  return (b == '0) ? a : a % b;
            default:  return '0;
        endcase
    endfunction

    function automatic string test_name(logic [op_w-1:0] op);
        if (op >= op_div_first) return "div";
        if (op >= op_mul) return "mul";
        return "alu";
    endfunction

    task automatic check_field(string test, string field, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s %s: expected %h, actual %h", test, field, exp, act);
            errors++;
        end
    endtask

    initial begin
        errors    = 0;
        delivered = 0;
        dropped   = 0;
        pending   = 0;
    end

    always @(posedge clk) begin
        if (!rst) begin
            idx = out_valid ? 1 : 0;  // skip the item sitting at the output
            if (fwd_valid) begin
                if (q.size() <= idx) begin
                    $display("forwarding raised with no matching item in the issue stage");
                    errors++;
                end else begin
                    check_field("forward", "addr", q[idx].rd, fwd_addr);
                    check_field("forward", "data", q[idx].result, fwd_data);
                    check_field("forward", "we", q[idx].we, fwd_valid);
                end
            end else if (!flush && q.size() > idx && op_q[idx] < op_div_first
                         && q[idx].we) begin
                // alu and mul items finish in their first cycle
                $display("forwarding stayed low for a finished %s op in the issue stage",
                         test_name(op_q[idx]));
                errors++;
            end
            if (out_valid && out_allowin) begin
                if (q.size() == 0) begin
                    $display("result delivered while no operation was pending");
                    errors++;
                end else begin
                    name = test_name(op_q[0]);
                    check_field(name, "pc", q[0].pc, out_pc);
                    check_field(name, "rd", q[0].rd, out_rd);
                    check_field(name, "we", q[0].we, out_we);
                    check_field(name, "result", q[0].result, out_result);
                    void'(q.pop_front());
                    void'(op_q.pop_front());
                    delivered++;
                end
            end
            if (flush) begin
                // only a held result register item survives
                while (q.size() > ((out_valid && !out_allowin) ? 1 : 0)) begin
                    void'(q.pop_back());
                    void'(op_q.pop_back());
                    dropped++;
                end
            end else if (in_valid && in_allowin) begin
                q.push_back(result_t'{pc: in_pc, rd: in_rd, we: in_we,
                                      result: model_result(in_op, in_src1, in_src2)});
                op_q.push_back(in_op);
            end
            pending = q.size();
        end
    end

endmodule

// File: tests/ex_top_chk.sv
`timescale 1ns/1ps

module ex_top_chk (
    input logic                          clk,
    input logic                          rst,
    input logic                          in_allowin,
    input logic                          out_valid,
    input logic                          out_allowin,
    input logic [ex_pipe_pkg::xlen-1:0]  out_pc,
    input logic [ex_pipe_pkg::reg_w-1:0] out_rd,
    input logic                          out_we,
    input logic [ex_pipe_pkg::xlen-1:0]  out_result,
    input logic                          fwd_valid,
    input logic                          div_ready
);

    int fails = 0;

    // stalled result register keeps its item
    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_allowin |=> out_valid && $stable(out_pc) && $stable(out_rd)
            && $stable(out_we) && $stable(out_result))
    else begin
        $error("result register changed while out_allowin was low");
        fails++;
    end

    reset_idle: assert property (@(posedge clk) $fell(rst) |-> !out_valid && !fwd_valid)
    else begin
        $error("valid outputs high right after reset");
        fails++;
    end

    // busy divider means the issue item is still waiting on it
    div_blocks: assert property (@(posedge clk) disable iff (rst)
        !div_ready |-> !in_allowin)
    else begin
        $error("issue stage took a new op while a division was pending");
        fails++;
    end

endmodule

// File: tests/tb_ex_top.sv
`timescale 1ns/1ps

module tb_ex_top;
    import ex_op_pkg::*;
    import ex_pipe_pkg::*;

    localparam int n_ops          = 400;
    localparam int timeout_cycles = n_ops * 40;

    logic             clk;
    logic             rst;
    logic             flush;
    logic             in_valid;
    logic [xlen-1:0]  in_pc;
    logic [op_w-1:0]  in_op;
    logic [xlen-1:0]  in_src1;
    logic [xlen-1:0]  in_src2;
    logic [reg_w-1:0] in_rd;
    logic             in_we;
    logic             out_allowin;
    logic             in_allowin;
    logic             out_valid;
    logic [xlen-1:0]  out_pc;
    logic [reg_w-1:0] out_rd;
    logic             out_we;
    logic [xlen-1:0]  out_result;
    logic             fwd_valid;
    logic [reg_w-1:0] fwd_addr;
    logic [xlen-1:0]  fwd_data;
    int               errors;
    int               delivered;
    int               dropped;
    int               pending;
    integer           seed;
    int               sent;
    int               cycles;
    logic             taken;

    ex_top DUT (.*);

    ex_monitor u_mon (.*);

    bind ex_top ex_top_chk u_chk (.*, .div_ready(u_unit.div_ready));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // mostly random operands, divide corner cases mixed in
    task automatic make_op();
        int pick;
        pick    = $unsigned($random(seed)) % 8;
        in_op   = $unsigned($random(seed)) % (op_modu + 1);
        in_src1 = $random(seed);
        in_src2 = $random(seed);
        if (pick == 0) begin
            in_src2 = '0;
        end else if (pick == 1) begin
            in_src1 = 32'h8000_0000;
            in_src2 = 32'hffff_ffff;
        end else if (pick == 2) begin
            in_src2 = in_src2 >> 24;  // small divisors
        end
        in_rd = $random(seed);
        in_we = $unsigned($random(seed)) % 4 != 0;
        in_pc = in_pc + 4;
    endtask

    initial begin
        seed        = 32'h216c2520;
        rst         = 1'b1;
        flush       = 1'b0;
        in_valid    = 1'b0;
        in_pc       = 32'h0000_1000;
        in_op       = '0;
        in_src1     = '0;
        in_src2     = '0;
        in_rd       = '0;
        in_we       = 1'b0;
        out_allowin = 1'b1;
        sent        = 0;
        taken       = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk) rst = 1'b0;
        while (sent < n_ops) begin
            @(negedge clk);
            if (taken) in_valid = 1'b0;
            if (!in_valid && $unsigned($random(seed)) % 4 != 0) begin
                make_op();
                in_valid = 1'b1;
            end
            out_allowin = $unsigned($random(seed)) % 10 >= 3;
            flush       = $unsigned($random(seed)) % 50 == 0;
            @(posedge clk);
            taken = in_valid & in_allowin;
            if (taken) sent++;
        end
        @(negedge clk);
        in_valid    = 1'b0;
        flush       = 1'b0;
        out_allowin = 1'b1;
        while (pending != 0) @(negedge clk);
        repeat (4) @(negedge clk);  // catch stray outputs
        $display("delivered %0d, flushed %0d, monitor errors %0d, assertion failures %0d",
                 delivered, dropped, errors, DUT.u_chk.fails);
        if (errors == 0 && DUT.u_chk.fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the run stalled", cycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: verilog/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    input  logic [ex_op_pkg::op_w-1:0]   op,
    input  logic [ex_pipe_pkg::xlen-1:0] a,
    input  logic [ex_pipe_pkg::xlen-1:0] b,
    output logic [ex_pipe_pkg::xlen-1:0] y
);
    import ex_op_pkg::*;
    import ex_pipe_pkg::*;

    logic [4:0]      shamt;
    logic [xlen-1:0] sum;
    logic [xlen-1:0] diff;

    assign shamt = b[4:0];
    assign sum   = a + b;
    assign diff  = a - b;

    always_comb begin
        case (op)
            op_add: begin
                y = sum;
            end
            op_sub: begin
                y = diff;
            end
            op_slt: begin
                y = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            end
            op_sltu: begin
                y = {{(xlen-1){1'b0}}, a < b};
            end
            op_and: begin
                y = a & b;
            end
            op_or: begin
                y = a | b;
            end
            op_nor: begin
                y = ~(a | b);
            end
            op_xor: begin
                y = a ^ b;
            end
            op_sll: begin
                y = a << shamt;
            end
            op_srl: begin
                y = a >> shamt;
            end
            op_sra: begin
                y = $signed(a) >>> shamt;
            end
            op_lui: begin
                y = b;  // decode already placed the immediate high
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

// File: verilog/ex_div.sv
`timescale 1ns/1ps

module ex_div (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cancel,
    input  logic                         req,
    input  logic                         is_signed,
    input  logic [ex_pipe_pkg::xlen-1:0] dividend,
    input  logic [ex_pipe_pkg::xlen-1:0] divisor,
    input  logic                         res_ready,
    output logic                         ready,
    output logic                         res_valid,
    output logic [ex_pipe_pkg::xlen-1:0] quotient,
    output logic [ex_pipe_pkg::xlen-1:0] remainder
);
    import ex_pipe_pkg::*;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_FIX,
        DIV_DONE
    } div_state_t;

    div_state_t              state;
    logic [$clog2(xlen)-1:0] step;
    logic [xlen-1:0]         quo_r;
    logic [xlen-1:0]         rem_r;
    logic [xlen-1:0]         dsr_r;
    logic                    neg_q;
    logic                    neg_r;
    logic                    by_zero;
    logic [xlen-1:0]         a_mag;
    logic [xlen-1:0]         b_mag;
    logic [xlen:0]           shifted;
    logic [xlen+1:0]         trial;

    assign ready     = (state == DIV_IDLE);
    assign res_valid = (state == DIV_DONE);

    assign a_mag = (is_signed & dividend[xlen-1]) ? -dividend : dividend;
    assign b_mag = (is_signed & divisor[xlen-1]) ? -divisor : divisor;

    // one restoring step, borrow out means the subtract does not fit
    assign shifted = {rem_r, quo_r[xlen-1]};
    assign trial   = {1'b0, shifted} - {2'b00, dsr_r};

    always_ff @(posedge clk) begin
        if (rst | cancel) begin
            state <= DIV_IDLE;
        end else begin
            case (state)
                DIV_IDLE: if (req) state <= DIV_RUN;
                DIV_RUN:  if (step == xlen - 1) state <= DIV_FIX;
                DIV_FIX:  state <= DIV_DONE;
                DIV_DONE: if (res_ready) state <= DIV_IDLE;
                default:  state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            DIV_IDLE: begin
                step    <= '0;
                quo_r   <= a_mag;
                rem_r   <= '0;
                dsr_r   <= b_mag;
                neg_q   <= is_signed & (dividend[xlen-1] ^ divisor[xlen-1]);
                neg_r   <= is_signed & dividend[xlen-1];
                by_zero <= (divisor == '0);
            end
            DIV_RUN: begin
                step  <= step + 1'b1;
                quo_r <= {quo_r[xlen-2:0], ~trial[xlen+1]};
                rem_r <= trial[xlen+1] ? shifted[xlen-1:0] : trial[xlen-1:0];
            end
            DIV_FIX: begin
                // min / -1 already lands on min with zero remainder
                quotient  <= by_zero ? '1 : (neg_q ? -quo_r : quo_r);
                remainder <= neg_r ? -rem_r : rem_r;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: verilog/ex_op_pkg.sv
package ex_op_pkg;

    localparam int op_w = 5;

    // alu class, codes 0 to 11
    localparam logic [op_w-1:0] op_add   = 5'd0;
    localparam logic [op_w-1:0] op_sub   = 5'd1;
    localparam logic [op_w-1:0] op_slt   = 5'd2;
    localparam logic [op_w-1:0] op_sltu  = 5'd3;
    localparam logic [op_w-1:0] op_and   = 5'd4;
    localparam logic [op_w-1:0] op_or    = 5'd5;
    localparam logic [op_w-1:0] op_nor   = 5'd6;
    localparam logic [op_w-1:0] op_xor   = 5'd7;
    localparam logic [op_w-1:0] op_sll   = 5'd8;
    localparam logic [op_w-1:0] op_srl   = 5'd9;
    localparam logic [op_w-1:0] op_sra   = 5'd10;
    localparam logic [op_w-1:0] op_lui   = 5'd11;

    // multiply class
    localparam logic [op_w-1:0] op_mul   = 5'd12;
    localparam logic [op_w-1:0] op_mulh  = 5'd13;
    localparam logic [op_w-1:0] op_mulhu = 5'd14;

    // divide class
    localparam logic [op_w-1:0] op_div   = 5'd15;
    localparam logic [op_w-1:0] op_mod   = 5'd16;
    localparam logic [op_w-1:0] op_divu  = 5'd17;
    localparam logic [op_w-1:0] op_modu  = 5'd18;

    // class boundaries, ops at or above belong to the class
    localparam logic [op_w-1:0] op_mul_first = op_mul;
    localparam logic [op_w-1:0] op_div_first = op_div;

endpackage

// File: verilog/ex_pipe_pkg.sv
package ex_pipe_pkg;

    localparam int xlen  = 32;
    localparam int reg_w = 5;

    // decoded op as it sits in the issue register
    typedef struct packed {
        logic [xlen-1:0]             pc;
        logic [ex_op_pkg::op_w-1:0]  op;
        logic [xlen-1:0]             src1;
        logic [xlen-1:0]             src2;
        logic [reg_w-1:0]            rd;
        logic                        we;
    } issue_t;

    // what the memory stage gets
    typedef struct packed {
        logic [xlen-1:0]  pc;
        logic [reg_w-1:0] rd;
        logic             we;
        logic [xlen-1:0]  result;
    } result_t;

endpackage

// File: verilog/ex_pipe_reg.sv
`timescale 1ns/1ps

module ex_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    input  logic     next_allowin,
    input  logic     ready_go,
    output logic     in_allowin,
    output logic     out_valid,
    output payload_t out_data
);

    logic valid;

    // empty, or the held item moves on this edge
    assign in_allowin = ~valid | ready_go & next_allowin;
    assign out_valid  = valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0; // also drops whatever arrives on this edge
        end else if (in_allowin) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid & in_allowin) begin
            out_data <= in_data;
        end
    end

endmodule

// File: verilog/ex_top.sv
`timescale 1ns/1ps

module ex_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          in_valid,
    input  logic [ex_pipe_pkg::xlen-1:0]  in_pc,
    input  logic [ex_op_pkg::op_w-1:0]    in_op,
    input  logic [ex_pipe_pkg::xlen-1:0]  in_src1,
    input  logic [ex_pipe_pkg::xlen-1:0]  in_src2,
    input  logic [ex_pipe_pkg::reg_w-1:0] in_rd,
    input  logic                          in_we,
    input  logic                          out_allowin,
    output logic                          in_allowin,
    output logic                          out_valid,
    output logic [ex_pipe_pkg::xlen-1:0]  out_pc,
    output logic [ex_pipe_pkg::reg_w-1:0] out_rd,
    output logic                          out_we,
    output logic [ex_pipe_pkg::xlen-1:0]  out_result,
    output logic                          fwd_valid,
    output logic [ex_pipe_pkg::reg_w-1:0] fwd_addr,
    output logic [ex_pipe_pkg::xlen-1:0]  fwd_data
);
    import ex_pipe_pkg::*;

    issue_t  issue_in;
    issue_t  issue_q;
    logic    issue_valid;
    logic    readygo;
    logic    res_allowin;
    result_t res_d;
    result_t res_q;

    assign issue_in = '{pc: in_pc, op: in_op, src1: in_src1, src2: in_src2,
                        rd: in_rd, we: in_we};

    ex_pipe_reg #(.payload_t(issue_t)) u_issue_reg (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .in_valid     (in_valid),
        .in_data      (issue_in),
        .next_allowin (res_allowin),
        .ready_go     (readygo),
        .in_allowin   (in_allowin),
        .out_valid    (issue_valid),
        .out_data     (issue_q)
    );

    ex_unit u_unit (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .stage_valid  (issue_valid),
        .stage_data   (issue_q),
        .next_allowin (res_allowin),
        .readygo      (readygo),
        .res_data     (res_d),
        .fwd_valid    (fwd_valid),
        .fwd_addr     (fwd_addr),
        .fwd_data     (fwd_data)
    );

    // result stage survives flush and always lets its item go
    ex_pipe_reg #(.payload_t(result_t)) u_result_reg (
        .clk          (clk),
        .rst          (rst),
        .flush        (1'b0),
        .in_valid     (readygo),
        .in_data      (res_d),
        .next_allowin (out_allowin),
        .ready_go     (1'b1),
        .in_allowin   (res_allowin),
        .out_valid    (out_valid),
        .out_data     (res_q)
    );

    assign out_pc     = res_q.pc;
    assign out_rd     = res_q.rd;
    assign out_we     = res_q.we;
    assign out_result = res_q.result;

endmodule

// File: verilog/ex_unit.sv
`timescale 1ns/1ps

module ex_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          stage_valid,
    input  ex_pipe_pkg::issue_t           stage_data,
    input  logic                          next_allowin,
    output logic                          readygo,
    output ex_pipe_pkg::result_t          res_data,
    output logic                          fwd_valid,
    output logic [ex_pipe_pkg::reg_w-1:0] fwd_addr,
    output logic [ex_pipe_pkg::xlen-1:0]  fwd_data
);
    import ex_op_pkg::*;
    import ex_pipe_pkg::*;

    typedef enum logic [1:0] {
        S_INIT,
        S_REQ,
        S_RES,
        S_DONE
    } unit_state_t;

    unit_state_t       state;
    logic              valid;
    logic              is_div;
    logic              is_mul;
    logic              mul_hi;
    logic              div_signed;
    logic              take_rem;
    logic [xlen-1:0]   alu_y;
    logic [xlen:0]     mul_a;
    logic [xlen:0]     mul_b;
    logic [2*xlen+1:0] prod;
    logic              div_req;
    logic              div_ready;
    logic              div_res_ready;
    logic              div_res_valid;
    logic [xlen-1:0]   div_quo;
    logic [xlen-1:0]   div_rem;
    logic [xlen-1:0]   div_res;
    logic [xlen-1:0]   result;

    assign valid = stage_valid & ~flush;  // a flushed item never completes

    assign is_div     = stage_data.op >= op_div_first;
    assign is_mul     = (stage_data.op >= op_mul_first) & ~is_div;
    assign mul_hi     = (stage_data.op == op_mulh) | (stage_data.op == op_mulhu);
    assign div_signed = (stage_data.op == op_div) | (stage_data.op == op_mod);
    assign take_rem   = (stage_data.op == op_mod) | (stage_data.op == op_modu);

    ex_alu u_alu (
        .op (stage_data.op),
        .a  (stage_data.src1),
        .b  (stage_data.src2),
        .y  (alu_y)
    );

    // 33x33 signed, top bit zero for mulhu
    assign mul_a = {(stage_data.op != op_mulhu) & stage_data.src1[xlen-1], stage_data.src1};
    assign mul_b = {(stage_data.op != op_mulhu) & stage_data.src2[xlen-1], stage_data.src2};
    assign prod  = $signed(mul_a) * $signed(mul_b);

    assign div_req       = valid & is_div & ((state == S_INIT) | (state == S_REQ));
    assign div_res_ready = (state == S_RES);

    ex_div u_div (
        .clk       (clk),
        .rst       (rst),
        .cancel    (flush),
        .req       (div_req),
        .is_signed (div_signed),
        .dividend  (stage_data.src1),
        .divisor   (stage_data.src2),
        .res_ready (div_res_ready),
        .ready     (div_ready),
        .res_valid (div_res_valid),
        .quotient  (div_quo),
        .remainder (div_rem)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_INIT;
        end else if (flush) begin
            state <= S_INIT;
        end else begin
            case (state)
                S_INIT:  if (div_req) state <= div_ready ? S_RES : S_REQ;
                S_REQ:   if (div_ready) state <= S_RES;
                S_RES:   if (div_res_valid) state <= S_DONE;
                S_DONE:  if (readygo & next_allowin) state <= S_INIT;
                default: state <= S_INIT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (div_res_valid & div_res_ready) begin
            div_res <= take_rem ? div_rem : div_quo;
        end
    end

    assign readygo = valid & (~is_div | (state == S_DONE));

    always_comb begin
        if (is_div) begin
            result = div_res;
        end else if (is_mul) begin
            result = mul_hi ? prod[2*xlen-1:xlen] : prod[xlen-1:0];
        end else begin
            result = alu_y;
        end
    end

    assign res_data = '{pc: stage_data.pc, rd: stage_data.rd, we: stage_data.we,
                        result: result};

    // same-cycle bypass back to decode
    assign fwd_valid = readygo & stage_data.we;
    assign fwd_addr  = stage_data.rd;
    assign fwd_data  = result;

endmodule

// File: vlog.f
verilog/ex_op_pkg.sv
verilog/ex_pipe_pkg.sv
verilog/ex_pipe_reg.sv
verilog/ex_alu.sv
verilog/ex_div.sv
verilog/ex_unit.sv
verilog/ex_top.sv
tests/ex_top_chk.sv
tests/ex_monitor.sv
tests/tb_ex_top.sv
